// ==== arrayMem.f ====
+incdir+include
hw/arrayMemPkg.sv
hw/arrayMemIf.sv
hw/arrayCommandDecoder.sv
hw/arrayDirectory.sv
hw/arrayElementStore.sv
hw/arrayResultStage.sv
hw/arrayMemTop.sv
verification/arrayMem_assert.sv
verification/arrayMemTb.sv

// ==== hw/arrayCommandDecoder.sv ====
//----------------------------------------------------------
// command decoder
// registers the raw command and turns the action code
// into one flag per supported command
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayCommandDecoder
  import arrayMemPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  actionT  action,
  input  arrayNoT arrayNo,
  input  indexT   elemIndex,
  input  dataT    dataIn,
  cmdIf.source    cmd
);

  actionT actionQ;   // registered code, zero is idle

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      actionQ <= '0;   // no command pending out of reset
    end else begin
      actionQ <= action;
    end
  end

  // operands, sampled every cycle
  always_ff @(posedge clock) begin
    cmd.arrayNo   <= arrayNo;
    cmd.elemIndex <= elemIndex;
    cmd.data      <= dataIn;
  end

  //--------------------------------------------------------
  // decode
  //--------------------------------------------------------
  assign cmd.doReset = (actionQ == `ACT_RESET);
  assign cmd.doWrite = (actionQ == `ACT_WRITE);
  assign cmd.doRead  = (actionQ == `ACT_READ);
  assign cmd.doSize  = (actionQ == `ACT_SIZE);
  assign cmd.doPush  = (actionQ == `ACT_PUSH);
  assign cmd.doPop   = (actionQ == `ACT_POP);
  assign cmd.doAlloc = (actionQ == `ACT_ALLOC);
  assign cmd.doFree  = (actionQ == `ACT_FREE);
  assign cmd.doAdd   = (actionQ == `ACT_ADD);
  assign cmd.doSub   = (actionQ == `ACT_SUBTRACT);

  // unknown codes leave every flag low
  assign cmd.valid = cmd.doReset | cmd.doWrite | cmd.doRead | cmd.doSize | cmd.doPush |
                     cmd.doPop | cmd.doAlloc | cmd.doFree | cmd.doAdd | cmd.doSub;

endmodule

// ==== hw/arrayDirectory.sv ====
//----------------------------------------------------------
// array directory
// allocation flags, sizes and freed stack; checks every
// command and plans the element access for the store
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayDirectory
  import arrayMemPkg::*;
(
  input  logic  clock,
  input  logic  resetN,
  cmdIf.sink    cmd,
  elemIf.director elem
);

  logic [`ARRAYS-1:0] allocated;               // array in use
  sizeT    sizes      [`ARRAYS];               // current length per array
  arrayNoT freedStack [`ARRAYS];               // freed arrays, reused first
  countT   allocCount;                         // arrays ever handed out
  countT   freedTop;                           // freed stack depth
  countT   topBelow;                           // slot under top of stack
  sizeT    curSize;
  sizeT    popSlot;
  arrayNoT allocNo;                            // array Alloc would return
  logic    fromFreed, unalloc, isFreed, outOfBounds;
  logic    needWriteable, needReadable, ok;
  errorT   errCode;

  assign curSize     = sizes[cmd.arrayNo];
  assign popSlot     = curSize - 1'b1;
  assign topBelow    = freedTop - 1'b1;
  assign fromFreed   = (freedTop != '0);
  assign allocNo     = fromFreed ? freedStack[topBelow[`ARRAY_BITS-1:0]]
                                 : allocCount[`ARRAY_BITS-1:0];
  assign unalloc     = ({1'b0, cmd.arrayNo} >= allocCount);
  assign isFreed     = !allocated[cmd.arrayNo];
  assign outOfBounds = ({1'b0, cmd.elemIndex} >= curSize);

  assign needReadable  = cmd.doRead | cmd.doAdd | cmd.doSub;
  assign needWriteable = needReadable | cmd.doWrite | cmd.doSize | cmd.doPush |
                         cmd.doPop | cmd.doFree;

  //--------------------------------------------------------
  // checks, first failure wins
  //--------------------------------------------------------
  always_comb begin
    errCode = `ERR_NONE;
    if (needWriteable) begin
      if (unalloc)                                            errCode = `ERR_UNALLOCATED;
      else if (isFreed)                                       errCode = `ERR_FREED;
      else if (needReadable && outOfBounds)                   errCode = `ERR_BOUNDS;
      else if (cmd.doPush && curSize == sizeT'(`ARRAY_LENGTH)) errCode = `ERR_FULL;
      else if (cmd.doPop && curSize == '0)                    errCode = `ERR_EMPTY;
    end else if (cmd.doAlloc && !fromFreed && allocCount == countT'(`ARRAYS)) begin
      errCode = `ERR_NO_MEMORY;  // pool exhausted
    end
  end

  assign ok = cmd.valid && (errCode == `ERR_NONE);

  // element access plan
  assign elem.writeEn   = ok && (cmd.doWrite || cmd.doPush);
  assign elem.addEn     = ok && cmd.doAdd;
  assign elem.subEn     = ok && cmd.doSub;
  assign elem.arrayNo   = cmd.arrayNo;
  assign elem.elemIndex = cmd.doPush ? curSize[`INDEX_BITS-1:0] :   // append at end
                          cmd.doPop  ? popSlot[`INDEX_BITS-1:0] :   // last element
                                       cmd.elemIndex;
  assign elem.operand   = cmd.data;

  // result fields
  assign elem.resultValid = cmd.valid;
  assign elem.resultError = errCode;
  assign elem.fromStore   = cmd.doWrite | cmd.doRead | cmd.doPop | cmd.doAdd | cmd.doSub;
  assign elem.directValue = cmd.doAlloc ? dataT'(allocNo) : dataT'(curSize);
  assign elem.keep        = (errCode != `ERR_NONE) | cmd.doPush | cmd.doFree | cmd.doReset;

  //--------------------------------------------------------
  // state update, only on a passing command
  //--------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      allocCount <= '0;
      freedTop   <= '0;
      for (int i = 0; i < `ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (ok) begin
      if (cmd.doReset) begin
        allocCount <= '0;          // sizes and flags left as they are
        freedTop   <= '0;
      end
      if (cmd.doWrite && outOfBounds) sizes[cmd.arrayNo] <= {1'b0, cmd.elemIndex} + 1'b1;
      if (cmd.doPush) sizes[cmd.arrayNo] <= curSize + 1'b1;
      if (cmd.doPop)  sizes[cmd.arrayNo] <= popSlot;
      if (cmd.doAlloc) begin
        allocated[allocNo] <= 1'b1;
        sizes[allocNo]     <= '0;  // new array starts empty
        if (fromFreed) freedTop <= topBelow;
        else           allocCount <= allocCount + 1'b1;
      end
      if (cmd.doFree) begin
        allocated[cmd.arrayNo] <= 1'b0;
        freedTop               <= freedTop + 1'b1;
      end
    end
  end

  // freed stack contents, only the depth matters after reset
  always_ff @(posedge clock) begin
    if (ok && cmd.doFree) freedStack[freedTop[`ARRAY_BITS-1:0]] <= cmd.arrayNo;
  end

endmodule

// ==== hw/arrayElementStore.sv ====
//----------------------------------------------------------
// element store
// array by element memory with write, add and subtract
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayElementStore
  import arrayMemPkg::*;
(
  input  logic clock,
  elemIf.store elem
);

  dataT mem [`ARRAYS][`ARRAY_LENGTH];   // one row per array
  logic update;

  // current content of the addressed element
  assign elem.oldValue = mem[elem.arrayNo][elem.elemIndex];

  //--------------------------------------------------------
  // new value, wraps at data width
  //--------------------------------------------------------
  always_comb begin
    if (elem.addEn) begin
      elem.newValue = elem.oldValue + elem.operand;
    end else if (elem.subEn) begin
      elem.newValue = elem.oldValue - elem.operand;
    end else begin
      elem.newValue = elem.operand;     // plain write / push
    end
  end

  assign update = elem.writeEn | elem.addEn | elem.subEn;

  always_ff @(posedge clock) begin
    if (update) begin
      mem[elem.arrayNo][elem.elemIndex] <= elem.newValue;
    end
  end

endmodule

// ==== hw/arrayMemIf.sv ====
//----------------------------------------------------------
// array memory internal buses
// cmdIf carries the decoded command into the directory,
// elemIf carries element access and result fields
//----------------------------------------------------------
`timescale 1ns/100ps

interface cmdIf
  import arrayMemPkg::*;
();
  arrayNoT arrayNo;    // registered operands
  indexT   elemIndex;
  dataT    data;
  logic    doReset, doWrite, doRead, doSize, doPush;   // one flag per command
  logic    doPop, doAlloc, doFree, doAdd, doSub;
  logic    valid;      // any flag set

  modport source (output arrayNo, elemIndex, data, doReset, doWrite, doRead, doSize,
                  doPush, doPop, doAlloc, doFree, doAdd, doSub, valid);
  modport sink   (input arrayNo, elemIndex, data, doReset, doWrite, doRead, doSize,
                  doPush, doPop, doAlloc, doFree, doAdd, doSub, valid);
endinterface

interface elemIf
  import arrayMemPkg::*;
();
  logic    writeEn, addEn, subEn;   // at most one high
  arrayNoT arrayNo;                 // element address
  indexT   elemIndex;
  dataT    operand;
  logic    resultValid;             // command present this cycle
  errorT   resultError;
  logic    fromStore;               // result comes from the store
  logic    keep;                    // leave dataOut alone
  dataT    directValue;             // size or allocated array number
  dataT    oldValue, newValue;      // element before / after update

  modport director (output writeEn, addEn, subEn, arrayNo, elemIndex, operand,
                    resultValid, resultError, fromStore, keep, directValue);
  modport store    (input writeEn, addEn, subEn, arrayNo, elemIndex, operand,
                    output oldValue, newValue);
  modport monitor  (input writeEn, addEn, subEn, resultValid, resultError, fromStore,
                    keep, directValue, oldValue, newValue);
endinterface

// ==== hw/arrayMemPkg.sv ====
//----------------------------------------------------------
// array memory types
// vector typedefs for every field that carries a meaning
//----------------------------------------------------------
`include "arrayMem_params.svh"

package arrayMemPkg;

  // command side
  typedef logic [`ACTION_BITS-1:0] actionT;   // raw command code
  typedef logic [`ARRAY_BITS-1:0]  arrayNoT;  // array number
  typedef logic [`INDEX_BITS-1:0]  indexT;    // element within array

  // one extra bit so a full array / full pool fits
  typedef logic [`INDEX_BITS:0]    sizeT;     // 0 .. ARRAY_LENGTH
  typedef logic [`ARRAY_BITS:0]    countT;    // 0 .. ARRAYS

  // payload and status
  typedef logic [`DATA_BITS-1:0]   dataT;     // element value
  typedef logic [`ERROR_BITS-1:0]  errorT;    // error code

endpackage

// ==== hw/arrayMemTop.sv ====
//----------------------------------------------------------
// array memory top level
// decoder, directory, element store and result stage
//----------------------------------------------------------
`timescale 1ns/100ps

module arrayMemTop
  import arrayMemPkg::*;
(
  input  logic    clock,
  input  logic    resetN,      // asynchronous, active low
  input  actionT  action,      // command strobe, zero is idle
  input  arrayNoT arrayNo,
  input  indexT   elemIndex,
  input  dataT    dataIn,
  output dataT    dataOut,
  output errorT   error,
  output logic    done         // result valid for one cycle
);

  cmdIf  cmdBus ();    // decoder -> directory
  elemIf elemBus ();   // directory -> store, result stage

  //--------------------------------------------------------
  // input side
  //--------------------------------------------------------
  arrayCommandDecoder decoder (
    .clock     (clock),
    .resetN    (resetN),
    .action    (action),
    .arrayNo   (arrayNo),
    .elemIndex (elemIndex),
    .dataIn    (dataIn),
    .cmd       (cmdBus.source)
  );

  // processing
  arrayDirectory directory (
    .clock  (clock),
    .resetN (resetN),
    .cmd    (cmdBus.sink),
    .elem   (elemBus.director)
  );

  arrayElementStore store (
    .clock (clock),
    .elem  (elemBus.store)
  );

  // output side
  arrayResultStage resultStage (
    .clock   (clock),
    .resetN  (resetN),
    .elem    (elemBus.monitor),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

endmodule

// ==== hw/arrayResultStage.sv ====
//----------------------------------------------------------
// result stage
// registers data out and error, one done pulse per command
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayResultStage
  import arrayMemPkg::*;
(
  input  logic   clock,
  input  logic   resetN,
  elemIf.monitor elem,
  output dataT   dataOut,
  output errorT  error,
  output logic   done
);

  dataT storeValue;

  // updating commands report the new word, read and pop the old one
  assign storeValue = (elem.writeEn || elem.addEn || elem.subEn) ? elem.newValue
                                                                 : elem.oldValue;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= `ERR_NONE;
      done    <= 1'b0;
    end else begin
      done <= elem.resultValid;   // single cycle per command
      if (elem.resultValid) begin
        error <= elem.resultError;
        if (!elem.keep) begin
          dataOut <= elem.fromStore ? storeValue : elem.directValue;
        end
      end
    end
  end

endmodule

// ==== include/arrayMem_params.svh ====
//----------------------------------------------------------
// array memory parameters
// field widths, pool shape, command and error codes
//----------------------------------------------------------
`ifndef ARRAYMEM_PARAMS_SVH
`define ARRAYMEM_PARAMS_SVH

`define ARRAY_BITS      3       // array number, 8 arrays
`define INDEX_BITS      2       // element index
`define ARRAY_LENGTH    4       // elements per array
`define ARRAYS          8       // arrays in the pool
`define DATA_BITS       12      // element width
`define ACTION_BITS     8       // command code width
`define ERROR_BITS      3       // error code width

// action codes, zero and unlisted values mean no command
`define ACT_RESET       8'd1
`define ACT_WRITE       8'd2
`define ACT_READ        8'd3
`define ACT_SIZE        8'd4
`define ACT_PUSH        8'd14
`define ACT_POP         8'd15
`define ACT_ALLOC       8'd18
`define ACT_FREE        8'd19
`define ACT_ADD         8'd20
`define ACT_SUBTRACT    8'd22

// error codes
`define ERR_NONE        3'd0
`define ERR_UNALLOCATED 3'd1    // above allocation counter
`define ERR_FREED       3'd2    // array sits on freed stack
`define ERR_BOUNDS      3'd3    // index not below size
`define ERR_FULL        3'd4    // push at full length
`define ERR_EMPTY       3'd5    // pop from empty array
`define ERR_NO_MEMORY   3'd6    // nothing left to allocate

`endif

// ==== runSim.sh ====
#!/bin/sh
# compile and run the array memory testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arrayMemTb \
  -f arrayMem.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/VarrayMemTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== verification/arrayMemTb.sv ====
//----------------------------------------------------------
// array memory testbench
// directed tests checked against a model of the array pool
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayMemTb
  import arrayMemPkg::*;
();

  localparam int TIMEOUT = 32;   // negedges allowed per burst

  logic    clock;
  logic    resetN;
  actionT  action;
  arrayNoT arrayNo;
  indexT   elemIndex;
  dataT    dataIn;
  dataT    dataOut;
  errorT   error;
  logic    done;

  integer  seed;
  int      errors;
  int      checks;
  logic    hung;              // set once a burst times out

  // pool model
  int      modelSize  [`ARRAYS];
  bit      modelAlloc [`ARRAYS];
  int      modelCount;
  arrayNoT modelFreed [$];     // back of queue is top of stack
  dataT    modelMem   [`ARRAYS][`ARRAY_LENGTH];
  dataT    lastOut;            // dataOut as the model sees it

  // commands waiting to be driven
  actionT  pendAct [$];
  arrayNoT pendArr [$];
  indexT   pendIdx [$];
  dataT    pendDat [$];

  arrayMemTop i_dut (
    .clock     (clock),
    .resetN    (resetN),
    .action    (action),
    .arrayNo   (arrayNo),
    .elemIndex (elemIndex),
    .dataIn    (dataIn),
    .dataOut   (dataOut),
    .error     (error),
    .done      (done)
  );

  always #50 clock = ~clock;   // 100 ns period

  function automatic dataT randomWord();
    return dataT'($random(seed));
  endfunction

  //--------------------------------------------------------
  // model of one command and its expected error
  //--------------------------------------------------------
  task automatic predict(input actionT act, input arrayNoT a, input indexT idx,
                         input dataT d, output errorT expErr);
    int      sz;
    logic    readable;
    arrayNoT pick;
    sz       = modelSize[a];
    readable = (act == `ACT_READ) || (act == `ACT_ADD) || (act == `ACT_SUBTRACT);
    expErr   = `ERR_NONE;
    if (act == `ACT_ALLOC) begin
      if (modelFreed.size() == 0 && modelCount == `ARRAYS) expErr = `ERR_NO_MEMORY;
    end else if (act != `ACT_RESET) begin
      if (int'(a) >= modelCount) expErr = `ERR_UNALLOCATED;   // counter first
      else if (!modelAlloc[a]) expErr = `ERR_FREED;
      else if (readable && int'(idx) >= sz) expErr = `ERR_BOUNDS;
      else if (act == `ACT_PUSH && sz == `ARRAY_LENGTH) expErr = `ERR_FULL;
      else if (act == `ACT_POP && sz == 0) expErr = `ERR_EMPTY;
    end
    if (expErr == `ERR_NONE) begin
      case (act)
        `ACT_RESET: begin
          modelCount = 0;          // flags and sizes survive
          modelFreed.delete();
        end
        `ACT_WRITE: begin
          modelMem[a][idx] = d;
          if (int'(idx) >= sz) modelSize[a] = int'(idx) + 1;
          lastOut = d;
        end
        `ACT_READ: lastOut = modelMem[a][idx];
        `ACT_SIZE: lastOut = dataT'(sz);
        `ACT_PUSH: begin
          modelMem[a][sz] = d;
          modelSize[a]    = sz + 1;
        end
        `ACT_POP: begin
          modelSize[a] = sz - 1;
          lastOut      = modelMem[a][sz-1];
        end
        `ACT_ALLOC: begin
          if (modelFreed.size() != 0) begin
            pick = modelFreed.pop_back();   // reuse freed first
          end else begin
            pick = arrayNoT'(modelCount);
            modelCount++;
          end
          modelAlloc[pick] = 1'b1;
          modelSize[pick]  = 0;
          lastOut          = dataT'(pick);
        end
        `ACT_FREE: begin
          modelAlloc[a] = 1'b0;
          modelFreed.push_back(a);
        end
        `ACT_ADD: begin
          modelMem[a][idx] = modelMem[a][idx] + d;   // wraps at 12 bits
          lastOut          = modelMem[a][idx];
        end
        `ACT_SUBTRACT: begin
          modelMem[a][idx] = modelMem[a][idx] - d;
          lastOut          = modelMem[a][idx];
        end
        default: ;
      endcase
    end
  endtask

  //--------------------------------------------------------
  // command helpers
  //--------------------------------------------------------
  task automatic queueCmd(input actionT act, input arrayNoT a, input indexT idx,
                          input dataT d);
    pendAct.push_back(act);
    pendArr.push_back(a);
    pendIdx.push_back(idx);
    pendDat.push_back(d);
  endtask

  task automatic dropPending();
    pendAct.delete();
    pendArr.delete();
    pendIdx.delete();
    pendDat.delete();
  endtask

  task automatic compareResult(input errorT wantErr, input dataT wantData);
    checks++;
    assert (error === wantErr) else begin
      $display("Fail at %0t: error expected %0d got %0d", $time, wantErr, error);
      errors++;
    end
    assert (dataOut === wantData) else begin
      $display("Fail at %0t: dataOut expected %h got %h", $time, wantData, dataOut);
      errors++;
    end
  endtask

  // drives queued commands one per cycle and checks each done in order
  task automatic runBurst();
    errorT expErr  [$];
    dataT  expData [$];
    errorT e;
    int    waited;
    waited = 0;
    if (hung) dropPending();
    while ((pendAct.size() != 0 || expErr.size() != 0) && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
      if (done === 1'b1) begin
        assert (expErr.size() != 0) else begin
          $display("done pulse at %0t with no command in flight", $time);
          errors++;
        end
        if (expErr.size() != 0) compareResult(expErr.pop_front(), expData.pop_front());
      end
      if (pendAct.size() != 0) begin
        action    = pendAct.pop_front();
        arrayNo   = pendArr.pop_front();
        elemIndex = pendIdx.pop_front();
        dataIn    = pendDat.pop_front();
        predict(action, arrayNo, elemIndex, dataIn, e);
        expErr.push_back(e);
        expData.push_back(lastOut);
      end else begin
        action = '0;   // idle
      end
    end
    if (expErr.size() != 0) begin
      $display("timeout at %0t: %0d results never arrived", $time, expErr.size());
      errors++;
      hung = 1'b1;
      dropPending();
    end
  endtask

  task automatic issue(input actionT act, input arrayNoT a, input indexT idx,
                       input dataT d);
    queueCmd(act, a, idx, d);
    runBurst();
  endtask

  task automatic closeTest(input string name, input int startErrors);
    $display("%s finished with %0d errors", name, errors - startErrors);
  endtask

  //--------------------------------------------------------
  // directed tests
  //--------------------------------------------------------
  task automatic testAllocOrder();
    int start;
    start = errors;
    for (int i = 0; i <= `ARRAYS; i++) begin
      issue(`ACT_ALLOC, 0, 0, 0);   // last one runs out of memory
    end
    issue(`ACT_FREE, 5, 0, 0);
    issue(`ACT_FREE, 2, 0, 0);
    issue(`ACT_ALLOC, 0, 0, 0);     // 2 comes back first
    issue(`ACT_ALLOC, 0, 0, 0);
    closeTest("allocation order", start);
  endtask

  task automatic testWriteRead();
    int start;
    start = errors;
    issue(`ACT_FREE, 7, 0, 0);
    issue(`ACT_ALLOC, 0, 0, 0);     // fresh array 7 of size 0
    issue(`ACT_WRITE, 7, 2, randomWord());
    issue(`ACT_SIZE, 7, 0, 0);
    issue(`ACT_READ, 7, 2, 0);
    issue(`ACT_READ, 7, 3, 0);      // past the end
    closeTest("write read size", start);
  endtask

  task automatic testPushPop();
    int start;
    start = errors;
    for (int i = 0; i <= `ARRAY_LENGTH; i++) begin
      issue(`ACT_PUSH, 6, 0, randomWord());
    end
    for (int i = 0; i <= `ARRAY_LENGTH; i++) begin
      issue(`ACT_POP, 6, 0, 0);
    end
    closeTest("push pop", start);
  endtask

  task automatic testArith();
    int start;
    start = errors;
    issue(`ACT_WRITE, 7, 0, 12'hff0);
    issue(`ACT_ADD, 7, 0, 12'h020);        // wraps past the top
    issue(`ACT_SUBTRACT, 7, 0, 12'h030);   // wraps below zero
    issue(`ACT_READ, 7, 0, 0);
    issue(`ACT_WRITE, 7, 1, randomWord());
    issue(`ACT_ADD, 7, 1, randomWord());
    issue(`ACT_SUBTRACT, 7, 1, randomWord());
    issue(`ACT_READ, 7, 1, 0);
    closeTest("add subtract", start);
  endtask

  task automatic testResetCmd();
    int start;
    start = errors;
    issue(`ACT_WRITE, 0, 1, randomWord());   // array 0 grows to size 2
    issue(`ACT_RESET, 0, 0, 0);
    issue(`ACT_ALLOC, 0, 0, 0);     // counter restarts at 0
    issue(`ACT_SIZE, 0, 0, 0);      // emptied by the new alloc
    // one command per cycle
    queueCmd(`ACT_WRITE, 0, 0, randomWord());
    queueCmd(`ACT_WRITE, 0, 1, randomWord());
    queueCmd(`ACT_READ, 0, 0, 0);
    queueCmd(`ACT_SIZE, 0, 0, 0);
    queueCmd(`ACT_ALLOC, 0, 0, 0);
    queueCmd(`ACT_PUSH, 1, 0, randomWord());
    queueCmd(`ACT_POP, 1, 0, 0);
    queueCmd(`ACT_ADD, 0, 1, randomWord());
    runBurst();
    closeTest("reset command", start);
  endtask

  task automatic testErrors();
    int start;
    start = errors;
    issue(`ACT_FREE, 1, 0, 0);
    issue(`ACT_READ, 1, 0, 0);       // freed
    issue(`ACT_WRITE, 1, 0, randomWord());
    issue(`ACT_FREE, 1, 0, 0);
    issue(`ACT_READ, 5, 0, 0);       // above the counter
    issue(`ACT_PUSH, 5, 0, randomWord());
    issue(`ACT_SIZE, 5, 0, 0);
    issue(`ACT_READ, 0, 0, 0);       // nothing moved
    issue(`ACT_SIZE, 0, 0, 0);
    issue(`ACT_ALLOC, 0, 0, 0);      // 1 sits on the freed stack once
    issue(`ACT_ALLOC, 0, 0, 0);      // counter still at 2
    closeTest("error checks", start);
  endtask

  //--------------------------------------------------------
  // main sequence
  //--------------------------------------------------------
  initial begin
    clock      = 1'b0;
    resetN     = 1'b0;
    action     = '0;
    arrayNo    = '0;
    elemIndex  = '0;
    dataIn     = '0;
    seed       = 32'h9e2895f6;
    errors     = 0;
    checks     = 0;
    hung       = 1'b0;
    modelCount = 0;
    lastOut    = '0;            // dataOut out of reset
    for (int i = 0; i < `ARRAYS; i++) begin
      modelSize[i]  = 0;
      modelAlloc[i] = 1'b0;
      for (int j = 0; j < `ARRAY_LENGTH; j++) begin
        modelMem[i][j] = '0;
      end
    end
    repeat (16) @(negedge clock);
    resetN = 1'b1;

    // outputs straight out of reset
    assert (done === 1'b0) else begin
      $display("Fail at %0t: done expected 0 got %b", $time, done);
      errors++;
    end
    compareResult(`ERR_NONE, lastOut);

    testAllocOrder();
    testWriteRead();
    testPushPop();
    testArith();
    testResetCmd();
    testErrors();

    $display("%0d results checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verification/arrayMem_assert.sv ====
//----------------------------------------------------------
// array memory port checks
// latency, error range and dataOut hold on errors
//----------------------------------------------------------
`timescale 1ns/100ps
`include "arrayMem_params.svh"

module arrayMemAssert
  import arrayMemPkg::*;
(
  input logic   clock,
  input logic   resetN,
  input actionT action,
  input dataT   dataOut,
  input errorT  error,
  input logic   done
);

  logic known;   // one of the kept command codes

  always_comb begin
    case (action)
      `ACT_RESET, `ACT_WRITE, `ACT_READ, `ACT_SIZE, `ACT_PUSH,
      `ACT_POP, `ACT_ALLOC, `ACT_FREE, `ACT_ADD, `ACT_SUBTRACT: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  // done follows each command by two edges
  doneLatency: assert property (@(posedge clock) disable iff (!resetN)
    done == $past(known, 2))
    else $error("done does not match a command two edges earlier");

  errorRange: assert property (@(posedge clock) disable iff (!resetN)
    error <= `ERR_NO_MEMORY)
    else $error("error code out of range");

  holdOnError: assert property (@(posedge clock) disable iff (!resetN)
    (done && error != `ERR_NONE) |-> $stable(dataOut))
    else $error("dataOut changed on a failed command");

endmodule

bind arrayMemTop arrayMemAssert portChecks (
  .clock   (clock),
  .resetN  (resetN),
  .action  (action),
  .dataOut (dataOut),
  .error   (error),
  .done    (done)
);
